// ==== l2cache.f ====
src/l2cache_pkg.sv
src/l2cache_fsm_main.sv
src/l2cache_req_buf.sv
src/l2cache_tagv.sv
src/l2cache_data.sv
src/l2cache_dirty_table.sv
src/l2cache_plru.sv
src/l2cache_top.sv
testbench/tb_clk_gen.sv
testbench/mem_model.sv
testbench/l2cache_tb.sv

// ==== Bender.yml ====
package:
  name: l2cache

sources:
  - src/l2cache_pkg.sv
  - src/l2cache_fsm_main.sv
  - src/l2cache_req_buf.sv
  - src/l2cache_tagv.sv
  - src/l2cache_data.sv
  - src/l2cache_dirty_table.sv
  - src/l2cache_plru.sv
  - src/l2cache_top.sv
  - target: simulation
    files:
      - testbench/tb_clk_gen.sv
      - testbench/mem_model.sv
      - testbench/l2cache_tb.sv

// ==== testbench/l2cache_tb.sv ====
`timescale 1ns/1ps

module l2cache_tb;
    import l2cache_pkg::*;

    localparam int NUM_REQS    = 68;
    localparam int MISS_CYCLES = 40;    // writeback plus refill at the longest memory delays
    localparam int CLK_PERIOD  = 4;
    localparam int COLD        = 0;
    localparam int HIT         = 1;
    localparam int ANY         = 2;

    logic  clk, rstn;
    logic  icache_req, icache_addr_ok, icache_data_ok;
    addr_t icache_addr;
    word_t icache_rdata;
    logic  dcache_req, dcache_wr, dcache_addr_ok, dcache_data_ok;
    addr_t dcache_addr;
    word_t dcache_wdata, dcache_rdata;
    strb_t dcache_wstrb;
    logic  mem_req_w, mem_req_r, mem_rdy, mem_addr_ok_w, mem_addr_ok_r, mem_data_ok;
    addr_t mem_addr;
    line_t mem_wdata, mem_rdata;

    logic [7:0] shadow [addr_t];    // every byte written so far
    addr_t      acc_line;
    logic       rd_done;
    int         errors = 0;
    int         checks = 0;
    int         cycle = 0;
    int         wb_count = 0;
    int         rd_count = 0;
    int         d_ok_cycle, i_ok_cycle;

    tb_clk_gen u_clk (.clk(clk), .rstn(rstn));

    mem_model u_mem (.*);

    l2cache_top UUT (.*);

    function automatic word_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic word_t expect_word(addr_t a);
        addr_t w;
        word_t v;
        w = {a[31:2], 2'b00};
        v = fill_word(w);
        for (int b = 0; b < 4; b++) begin
            if (shadow.exists(w + b)) begin
                v[b*8 +: 8] = shadow[w + b];
            end
        end
        return v;
    endfunction

    function automatic line_t expect_line(addr_t a);
        line_t l;
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = expect_word({a[31:4], 4'h0} + 4 * k);
        end
        return l;
    endfunction

    function automatic addr_t rand_addr(index_t set);
        return {tag_t'($urandom), set, 2'($urandom), 2'b00};
    endfunction

    task automatic report_mismatch(input string name, input line_t exp, input line_t got);
        $display("mismatch %s exp %0h got %0h", name, exp, got);
        errors++;
    endtask

    task automatic count_failure(input string msg);
        $display("%s", msg);
        errors++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // protocol checks
    ////////////////////////////////////////////////////////////////////////////
    hold_w: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_w && !mem_addr_ok_w |=> mem_req_w)
        else count_failure("mem_req_w dropped before mem_addr_ok_w");
    hold_r: assert property (@(posedge clk) disable iff (!rstn)
        mem_req_r && !mem_addr_ok_r |=> mem_req_r)
        else count_failure("mem_req_r dropped before mem_addr_ok_r");
    rdy_held: assert property (@(posedge clk) disable iff (!rstn) mem_data_ok |-> mem_rdy)
        else count_failure("mem_data_ok arrived while mem_rdy was low");
    one_side: assert property (@(posedge clk) disable iff (!rstn)
        !(icache_addr_ok && dcache_addr_ok) && !(icache_data_ok && dcache_data_ok))
        else count_failure("both L1 sides answered in one cycle");

    // shadow update and memory traffic checks
    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= 1 && cycle <= 4) begin
            assert (!(icache_addr_ok | dcache_addr_ok | icache_data_ok | dcache_data_ok |
                      mem_req_r | mem_req_w | mem_rdy))
            else count_failure("a strobe was high during or just after reset");
        end
        if (dcache_addr_ok || icache_addr_ok) begin
            acc_line = {(dcache_addr_ok ? dcache_addr[31:4] : icache_addr[31:4]), 4'h0};
            rd_done  = 1'b0;
        end
        if (dcache_addr_ok && dcache_wr) begin
            for (int b = 0; b < 4; b++) begin
                if (dcache_wstrb[b]) shadow[{dcache_addr[31:2], 2'b00} + b] = dcache_wdata[b*8 +: 8];
            end
        end
        if (mem_req_w && mem_addr_ok_w) begin
            wb_count++;
            assert (!rd_done && mem_addr[9:0] == acc_line[9:0] &&
                    mem_addr[31:10] != acc_line[31:10])
            else count_failure($sformatf("writeback of line %h out of place", mem_addr));
            assert (mem_wdata == expect_line(mem_addr))
            else report_mismatch("mem_wdata", expect_line(mem_addr), mem_wdata);
        end
        if (mem_req_r && mem_addr_ok_r) begin
            rd_count++;
            rd_done = 1'b1;
            assert (mem_addr == acc_line) else report_mismatch("mem_addr", acc_line, mem_addr);
        end
    end

    task automatic write_word(input addr_t a, input word_t d, input strb_t s);
        @(negedge clk);
        dcache_req   = 1'b1;
        dcache_wr    = 1'b1;
        dcache_addr  = a;
        dcache_wdata = d;
        dcache_wstrb = s;
        do begin
            @(posedge clk);
        end while (!dcache_addr_ok);
        @(negedge clk);
        dcache_req = 1'b0;
        dcache_wr  = 1'b0;
    endtask

    task automatic read_check(input bit from_icache, input addr_t a, input int kind);
        int    lat, wb0, rd0;
        word_t exp, got;
        @(negedge clk);
        if (from_icache) begin
            icache_req  = 1'b1;
            icache_addr = a;
        end else begin
            dcache_req  = 1'b1;
            dcache_wr   = 1'b0;
            dcache_addr = a;
        end
        do begin
            @(posedge clk);
        end while (!(from_icache ? icache_addr_ok : dcache_addr_ok));
        if (from_icache) i_ok_cycle = cycle;
        else d_ok_cycle = cycle;
        wb0 = wb_count;
        rd0 = rd_count;
        @(negedge clk);
        if (from_icache) icache_req = 1'b0;
        else dcache_req = 1'b0;
        lat = 0;
        do begin
            @(posedge clk);
            lat++;
        end while (!(from_icache ? icache_data_ok : dcache_data_ok));
        got = from_icache ? icache_rdata : dcache_rdata;
        exp = expect_word(a);
        assert (got == exp) else report_mismatch(from_icache ? "icache_rdata" : "dcache_rdata",
                                                 exp, got);
        if (kind == HIT) begin
            assert (lat == 1 && wb_count == wb0 && rd_count == rd0)
            else count_failure($sformatf("read hit at %h took %0d cycles or used memory", a, lat));
        end else if (kind == COLD) begin
            assert (wb_count == wb0 && rd_count == rd0 + 1)
            else count_failure($sformatf("cold miss at %h made wrong memory traffic", a));
        end
        checks++;
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        addr_t a;
        addr_t hot [8];
        addr_t ev [5];
        int    wb_base;
        void'($urandom(87));
        icache_req   = 1'b0;
        icache_addr  = '0;
        dcache_req   = 1'b0;
        dcache_wr    = 1'b0;
        dcache_addr  = '0;
        dcache_wdata = '0;
        dcache_wstrb = '0;
        wait (rstn);
        repeat (2) @(negedge clk);
        for (int i = 0; i < 8; i++) begin          // cold misses, one set each
            hot[i] = rand_addr(index_t'(i));
            read_check(i[0], hot[i], COLD);
        end
        for (int i = 0; i < 8; i++) begin
            read_check(!i[0], {hot[i][31:4], 2'($urandom), 2'b00}, HIT);
        end
        // write hits, then write misses that allocate
        for (int i = 0; i < 8; i++) begin
            a = (i < 4) ? hot[i] : rand_addr(index_t'(16 + i));
            write_word(a, $urandom, strb_t'($urandom));
            read_check(1'b0, a, HIT);
        end
        // five tags into one set, so dirty lines must leave
        wb_base = wb_count;
        for (int i = 0; i < 5; i++) begin
            ev[i] = {19'($urandom), 3'(i), index_t'(40), 2'($urandom), 2'b00};
            write_word(ev[i], $urandom, 4'hf);
        end
        for (int i = 0; i < 5; i++) read_check(i[0], ev[i], ANY);
        assert (wb_count > wb_base) else count_failure("no writeback while evicting dirty lines");
        fork
            read_check(1'b0, rand_addr(index_t'(50)), COLD);
            read_check(1'b1, rand_addr(index_t'(51)), COLD);
        join
        assert (d_ok_cycle < i_ok_cycle) else count_failure("icache was accepted before dcache");
        for (int i = 0; i < 24; i++) begin         // churn two sets
            a = {19'h2a5c1, 3'($urandom), index_t'(60 + ($urandom % 2)), 2'($urandom), 2'b00};
            if ($urandom % 2) write_word(a, $urandom, strb_t'($urandom));
            else read_check(i[0], a, ANY);
        end
        repeat (2) @(negedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

    initial begin
        #((NUM_REQS * MISS_CYCLES + 100) * CLK_PERIOD);
        $display("timeout after %0d cycles, the cache stopped answering", cycle);
        $display("Simulation failed");
        $finish;
    end

endmodule

// ==== testbench/mem_model.sv ====
`timescale 1ns/1ps

module mem_model (
    input  logic               clk,
    input  logic               rstn,
    input  logic               mem_req_w,
    input  logic               mem_req_r,
    input  l2cache_pkg::addr_t mem_addr,
    input  l2cache_pkg::line_t mem_wdata,
    output logic               mem_addr_ok_w,
    output logic               mem_addr_ok_r,
    output logic               mem_data_ok,
    output l2cache_pkg::line_t mem_rdata
);
    import l2cache_pkg::*;

    line_t lines [addr_t];      // sparse store keyed by line address
    addr_t rd_addr;

    // untouched words read back a pattern of their whole address
    function automatic word_t fill_word(addr_t a);
        return {a[15:0], a[31:16]} ^ 32'h5a3c_96e1;
    endfunction

    function automatic line_t read_line(addr_t a);
        line_t l;
        if (lines.exists(a)) begin
            return lines[a];
        end
        for (int k = 0; k < 4; k++) begin
            l[k*32 +: 32] = fill_word(a + 4 * k);
        end
        return l;
    endfunction

    task automatic wait_cycles();
        repeat ($urandom % 6) @(negedge clk);
    endtask

    initial begin
        mem_addr_ok_w = 1'b0;
        mem_addr_ok_r = 1'b0;
        mem_data_ok   = 1'b0;
        mem_rdata     = '0;
        forever begin
            @(negedge clk);
            if (rstn && mem_req_w) begin
                wait_cycles();
                lines[mem_addr] = mem_wdata;
                mem_addr_ok_w   = 1'b1;
                @(negedge clk);
                mem_addr_ok_w = 1'b0;
            end else if (rstn && mem_req_r) begin
                rd_addr = mem_addr;
                wait_cycles();
                mem_addr_ok_r = 1'b1;
                @(negedge clk);
                mem_addr_ok_r = 1'b0;
                wait_cycles();              // cache sits in refill with mem_rdy
                mem_rdata   = read_line(rd_addr);
                mem_data_ok = 1'b1;
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

endmodule

// ==== testbench/tb_clk_gen.sv ====
`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk,
    output logic rstn
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;      // 4 ns period
    end

    initial begin
        rstn = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
    end

endmodule

// ==== src/l2cache_top.sv ====
`timescale 1ns/1ps

module l2cache_top (
    input  logic               clk,
    input  logic               rstn,
    // icache
    input  logic               icache_req,
    input  l2cache_pkg::addr_t icache_addr,
    output logic               icache_addr_ok,
    output logic               icache_data_ok,
    output l2cache_pkg::word_t icache_rdata,
    // dcache
    input  logic               dcache_req,
    input  logic               dcache_wr,
    input  l2cache_pkg::addr_t dcache_addr,
    input  l2cache_pkg::word_t dcache_wdata,
    input  l2cache_pkg::strb_t dcache_wstrb,
    output logic               dcache_addr_ok,
    output logic               dcache_data_ok,
    output l2cache_pkg::word_t dcache_rdata,
    // memory
    output logic               mem_req_w,
    output logic               mem_req_r,
    output logic               mem_rdy,
    output l2cache_pkg::addr_t mem_addr,
    output l2cache_pkg::line_t mem_wdata,
    input  logic               mem_addr_ok_w,
    input  logic               mem_addr_ok_r,
    input  logic               mem_data_ok,
    input  l2cache_pkg::line_t mem_rdata
);
    import l2cache_pkg::*;

    logic     buf_we, dirty, wb_sel;
    src_t     buf_src;
    addr_t    buf_addr;
    word_t    buf_wdata, rd_word;
    strb_t    buf_wstrb;
    way_vec_t hit, valid;
    way_t     victim, tagv_way, data_way, dirty_way, plru_way;
    logic     tagv_we, data_line_we, data_word_we;
    logic     dirty_set, dirty_clr, plru_touch;
    tag_t     wb_tag, buf_tag;
    index_t   buf_index;
    line_t    wb_line;

    assign buf_tag   = buf_addr[OFFSET_WIDTH+INDEX_WIDTH+2 +: TAG_WIDTH];
    assign buf_index = buf_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];

    // line aligned, victim tag while writing back
    assign mem_addr     = {wb_sel ? wb_tag : buf_tag, buf_index, {(OFFSET_WIDTH+2){1'b0}}};
    assign mem_wdata    = wb_line;
    assign icache_rdata = rd_word;
    assign dcache_rdata = rd_word;

    l2cache_fsm_main u_fsm (.*);

    l2cache_req_buf u_req_buf (.*);

    l2cache_tagv u_tagv (.*);

    l2cache_data u_data (.*);

    l2cache_dirty_table u_dirty (.*);

    l2cache_plru u_plru (.*);

endmodule

// ==== src/l2cache_plru.sv ====
`timescale 1ns/1ps

module l2cache_plru (
    input  logic                  clk,
    input  logic                  rstn,
    input  l2cache_pkg::addr_t    buf_addr,
    input  logic                  plru_touch,
    input  l2cache_pkg::way_t     plru_way,
    input  l2cache_pkg::way_vec_t valid,
    output l2cache_pkg::way_t     victim
);
    import l2cache_pkg::*;

    // bit 0 root, bit 1 ways 0/1, bit 2 ways 2/3
    logic [NUM_SETS-1:0][2:0] tree_q;
    logic [2:0]               tree;
    index_t                   idx;

    assign idx  = buf_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];
    assign tree = tree_q[idx];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            tree_q <= '0;
        end else if (plru_touch) begin
            tree_q[idx][0] <= ~plru_way[1];     // point away from the used half
            if (plru_way[1]) begin
                tree_q[idx][2] <= ~plru_way[0];
            end else begin
                tree_q[idx][1] <= ~plru_way[0];
            end
        end
    end

    always_comb begin
        victim = tree[0] ? {1'b1, tree[2]} : {1'b0, tree[1]};
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (!valid[w]) begin
                victim = way_t'(w);         // free way before tree
            end
        end
    end

endmodule

// ==== src/l2cache_dirty_table.sv ====
`timescale 1ns/1ps

module l2cache_dirty_table (
    input  logic               clk,
    input  logic               rstn,
    input  l2cache_pkg::addr_t buf_addr,
    input  logic               dirty_set,
    input  logic               dirty_clr,
    input  l2cache_pkg::way_t  dirty_way,
    output logic               dirty
);
    import l2cache_pkg::*;

    way_vec_t [NUM_SETS-1:0] dirty_q;
    index_t                  idx;

    assign idx   = buf_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];
    assign dirty = dirty_q[idx][dirty_way];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dirty_q <= '0;
        end else if (dirty_set) begin
            dirty_q[idx][dirty_way] <= 1'b1;
        end else if (dirty_clr) begin
            dirty_q[idx][dirty_way] <= 1'b0;
        end
    end

endmodule

// ==== src/l2cache_data.sv ====
`timescale 1ns/1ps

module l2cache_data (
    input  logic                  clk,
    input  l2cache_pkg::addr_t    buf_addr,
    input  l2cache_pkg::word_t    buf_wdata,
    input  l2cache_pkg::strb_t    buf_wstrb,
    input  l2cache_pkg::src_t     buf_src,
    input  logic                  data_line_we,
    input  logic                  data_word_we,
    input  l2cache_pkg::way_t     data_way,
    input  l2cache_pkg::way_vec_t hit,
    input  l2cache_pkg::line_t    mem_rdata,
    output l2cache_pkg::word_t    rd_word,
    output l2cache_pkg::line_t    wb_line
);
    import l2cache_pkg::*;

    line_t                   data_q [NUM_SETS][NUM_WAYS];
    index_t                  idx;
    logic [OFFSET_WIDTH-1:0] offset;
    line_t                   hit_line;
    line_t                   src_line;

    // byte-strobed word into a line
    function automatic line_t merge_word(line_t line, word_t wdata, strb_t wstrb,
                                         logic [OFFSET_WIDTH-1:0] woff);
        line_t merged;
        merged = line;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                merged[woff*32 + b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return merged;
    endfunction

    assign idx    = buf_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];
    assign offset = buf_addr[2 +: OFFSET_WIDTH];

    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (hit[w]) begin
                hit_line = hit_line | data_q[idx][w];
            end
        end
    end

    assign src_line = data_line_we ? mem_rdata : hit_line;     // refill bypass
    assign rd_word  = src_line[offset*32 +: 32];
    assign wb_line  = data_q[idx][data_way];

    always_ff @(posedge clk) begin
        if (data_line_we) begin
            data_q[idx][data_way] <= (buf_src == SRC_DWRITE) ?
                merge_word(mem_rdata, buf_wdata, buf_wstrb, offset) : mem_rdata;
        end else if (data_word_we) begin
            data_q[idx][data_way] <= merge_word(data_q[idx][data_way], buf_wdata,
                                                buf_wstrb, offset);
        end
    end

endmodule

// ==== src/l2cache_tagv.sv ====
`timescale 1ns/1ps

module l2cache_tagv (
    input  logic                  clk,
    input  logic                  rstn,
    input  l2cache_pkg::addr_t    buf_addr,
    input  logic                  tagv_we,
    input  l2cache_pkg::way_t     tagv_way,
    input  logic                  wb_sel,
    output l2cache_pkg::way_vec_t hit,
    output l2cache_pkg::way_vec_t valid,
    output l2cache_pkg::tag_t     wb_tag
);
    import l2cache_pkg::*;

    tag_t                      tag_q [NUM_SETS][NUM_WAYS];
    way_vec_t [NUM_SETS-1:0]   valid_q;
    index_t                    idx;
    tag_t                      buf_tag;

    assign idx     = buf_addr[OFFSET_WIDTH+2 +: INDEX_WIDTH];
    assign buf_tag = buf_addr[OFFSET_WIDTH+INDEX_WIDTH+2 +: TAG_WIDTH];
    assign valid   = valid_q[idx];

    always_comb begin
        for (int w = 0; w < NUM_WAYS; w++) begin
            hit[w] = valid_q[idx][w] && (tag_q[idx][w] == buf_tag);
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            valid_q <= '0;
        end else if (tagv_we) begin
            valid_q[idx][tagv_way] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (tagv_we) begin
            tag_q[idx][tagv_way] <= buf_tag;
        end
    end

    // victim tag kept for the writeback address
    always_ff @(posedge clk) begin
        if (wb_sel) begin
            wb_tag <= tag_q[idx][tagv_way];
        end
    end

endmodule

// ==== src/l2cache_req_buf.sv ====
`timescale 1ns/1ps

module l2cache_req_buf (
    input  logic               clk,
    input  logic               rstn,
    input  logic               buf_we,
    input  logic               icache_req,
    input  l2cache_pkg::addr_t icache_addr,
    input  logic               dcache_req,
    input  logic               dcache_wr,
    input  l2cache_pkg::addr_t dcache_addr,
    input  l2cache_pkg::word_t dcache_wdata,
    input  l2cache_pkg::strb_t dcache_wstrb,
    output l2cache_pkg::src_t  buf_src,
    output l2cache_pkg::addr_t buf_addr,
    output l2cache_pkg::word_t buf_wdata,
    output l2cache_pkg::strb_t buf_wstrb
);
    import l2cache_pkg::*;

    // source code, the only control state here
    always_ff @(posedge clk) begin
        if (!rstn) begin
            buf_src <= SRC_NONE;
        end else if (buf_we) begin
            if (dcache_req) begin
                buf_src <= dcache_wr ? SRC_DWRITE : SRC_DREAD;
            end else if (icache_req) begin
                buf_src <= SRC_IREAD;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (buf_we) begin
            if (dcache_req) begin           // dcache first
                buf_addr  <= dcache_addr;
                buf_wdata <= dcache_wdata;
                buf_wstrb <= dcache_wstrb;
            end else if (icache_req) begin
                buf_addr  <= icache_addr;
                buf_wstrb <= '0;
            end
        end
    end

endmodule

// ==== src/l2cache_fsm_main.sv ====
`timescale 1ns/1ps

module l2cache_fsm_main (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  icache_req,
    input  logic                  dcache_req,
    input  logic                  dcache_wr,
    input  l2cache_pkg::src_t     buf_src,
    input  l2cache_pkg::way_vec_t hit,
    input  l2cache_pkg::way_vec_t valid,
    input  l2cache_pkg::way_t     victim,
    input  logic                  dirty,
    input  logic                  mem_addr_ok_w,
    input  logic                  mem_addr_ok_r,
    input  logic                  mem_data_ok,
    output logic                  icache_addr_ok,
    output logic                  dcache_addr_ok,
    output logic                  icache_data_ok,
    output logic                  dcache_data_ok,
    output logic                  buf_we,
    output logic                  mem_req_w,
    output logic                  mem_req_r,
    output logic                  mem_rdy,
    output logic                  tagv_we,
    output l2cache_pkg::way_t     tagv_way,
    output logic                  data_line_we,
    output logic                  data_word_we,
    output l2cache_pkg::way_t     data_way,
    output logic                  dirty_set,
    output logic                  dirty_clr,
    output l2cache_pkg::way_t     dirty_way,
    output logic                  plru_touch,
    output l2cache_pkg::way_t     plru_way,
    output logic                  wb_sel
);
    import l2cache_pkg::*;

    fsm_state_t state, next_state;
    way_t       sel;        // victim way latched for the whole miss
    logic       we_sel;
    way_t       hit_pos;
    src_t       req_src;    // arbitration result in idle

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= ST_IDLE;
            sel   <= '0;
        end else begin
            state <= next_state;
            if (we_sel) begin
                sel <= victim;
            end
        end
    end

    // lowest hitting way wins
    always_comb begin
        hit_pos = '0;
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
            if (hit[w]) begin
                hit_pos = way_t'(w);
            end
        end
    end

    assign req_src = dcache_req ? (dcache_wr ? SRC_DWRITE : SRC_DREAD) :
                     icache_req ? SRC_IREAD : SRC_NONE;

    ////////////////////////////////////////////////////////////////////////////
    // next state
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE:         if (req_src != SRC_NONE) next_state = ST_LOOKUP;
            ST_LOOKUP:       next_state = (|hit) ? ST_IDLE : ST_CHECK_DIRTY;
            ST_CHECK_DIRTY:  next_state = ST_CHECK_DIRTY1;
            ST_CHECK_DIRTY1: next_state = (dirty && valid[sel]) ? ST_WRITEBACK : ST_REPLACE1;
            ST_WRITEBACK:    if (mem_addr_ok_w) next_state = ST_REPLACE1;
            ST_REPLACE1:     if (mem_addr_ok_r) next_state = ST_REPLACE2;
            ST_REPLACE2:     if (mem_data_ok) next_state = ST_IDLE;
            default:         next_state = ST_IDLE;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // strobes
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        icache_addr_ok = 1'b0;
        dcache_addr_ok = 1'b0;
        icache_data_ok = 1'b0;
        dcache_data_ok = 1'b0;
        buf_we         = 1'b0;
        mem_req_w      = 1'b0;
        mem_req_r      = 1'b0;
        mem_rdy        = 1'b0;
        tagv_we        = 1'b0;
        tagv_way       = sel;
        data_line_we   = 1'b0;
        data_word_we   = 1'b0;
        data_way       = sel;
        dirty_set      = 1'b0;
        dirty_clr      = 1'b0;
        dirty_way      = sel;
        plru_touch     = 1'b0;
        plru_way       = sel;
        wb_sel         = 1'b0;
        we_sel         = 1'b0;
        case (state)
            ST_IDLE: begin
                buf_we         = (req_src != SRC_NONE);
                dcache_addr_ok = (req_src == SRC_DREAD) || (req_src == SRC_DWRITE);
                icache_addr_ok = (req_src == SRC_IREAD);
            end
            ST_LOOKUP: begin
                if (|hit) begin
                    plru_touch = 1'b1;
                    plru_way   = hit_pos;
                    data_way   = hit_pos;
                    if (buf_src == SRC_DWRITE) begin
                        data_word_we = 1'b1;
                        dirty_set    = 1'b1;
                        dirty_way    = hit_pos;
                    end else begin
                        icache_data_ok = (buf_src == SRC_IREAD);
                        dcache_data_ok = (buf_src == SRC_DREAD);
                    end
                end
            end
            ST_CHECK_DIRTY: begin
                we_sel = 1'b1;
            end
            ST_CHECK_DIRTY1: begin
                wb_sel = dirty && valid[sel];   // grab the victim tag early
            end
            ST_WRITEBACK: begin
                mem_req_w = 1'b1;
                wb_sel    = 1'b1;
            end
            ST_REPLACE1: mem_req_r = 1'b1;
            ST_REPLACE2: begin
                mem_rdy = 1'b1;
                if (mem_data_ok) begin
                    tagv_we      = 1'b1;
                    data_line_we = 1'b1;
                    plru_touch   = 1'b1;
                    if (buf_src == SRC_DWRITE) begin
                        dirty_set = 1'b1;       // write merged into the refill
                    end else begin
                        dirty_clr      = 1'b1;
                        icache_data_ok = (buf_src == SRC_IREAD);
                        dcache_data_ok = (buf_src == SRC_DREAD);
                    end
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== src/l2cache_pkg.sv ====
package l2cache_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int NUM_WAYS     = 4;
    localparam int OFFSET_WIDTH = 2;    // word offset within a line
    localparam int INDEX_WIDTH  = 6;
    localparam int TAG_WIDTH    = 32 - INDEX_WIDTH - OFFSET_WIDTH - 2;
    localparam int NUM_SETS     = 1 << INDEX_WIDTH;

    typedef logic [31:0]                   addr_t;
    typedef logic [31:0]                   word_t;
    typedef logic [3:0]                    strb_t;
    typedef logic [127:0]                  line_t;
    typedef logic [TAG_WIDTH-1:0]          tag_t;
    typedef logic [INDEX_WIDTH-1:0]        index_t;
    typedef logic [NUM_WAYS-1:0]           way_vec_t;
    typedef logic [$clog2(NUM_WAYS)-1:0]   way_t;

    // requester code held in the request buffer
    typedef logic [1:0] src_t;
    localparam src_t SRC_NONE   = 2'b00;
    localparam src_t SRC_IREAD  = 2'b01;
    localparam src_t SRC_DREAD  = 2'b10;
    localparam src_t SRC_DWRITE = 2'b11;

    typedef enum logic [2:0] {
        ST_IDLE,
        ST_LOOKUP,
        ST_CHECK_DIRTY,
        ST_CHECK_DIRTY1,
        ST_WRITEBACK,
        ST_REPLACE1,
        ST_REPLACE2
    } fsm_state_t;

endpackage
